//--- hdl/qos_pkg.sv
package qos_pkg;

    // Width of the burst length field in each requester configuration
    localparam int BURST_LEN_WIDTH = 4;

    // QoS levels, a larger encoding means a more urgent requester
    typedef enum logic [1:0] {
        QOS_LEVEL_MEDIUM      = 2'd0, // Background traffic
        QOS_LEVEL_MEDIUM_HIGH = 2'd1,
        QOS_LEVEL_HIGH        = 2'd2,
        QOS_LEVEL_CRITICAL    = 2'd3  // Always served first when present
    } qos_level_t;

    // Configuration presented by a requester together with its valid level
    // The burst length counts beats minus one so a zero means a single beat
    typedef struct packed {
        qos_level_t                 qos_level; // Arbitration priority of the burst
        logic [BURST_LEN_WIDTH-1:0] burst_len; // Beats in the burst minus one
    } qos_config_t;

endpackage

//--- hdl/port_pkg.sv
package port_pkg;

    // Number of requesters sharing the output stream
    localparam int NUM_REQUESTERS = 4;

    // Width of the data word carried by every beat
    localparam int DATA_WIDTH = 32;

    // Enough bits to name any requester, never less than one
    localparam int REQ_ID_WIDTH = (NUM_REQUESTERS > 1) ? $clog2(NUM_REQUESTERS) : 1;

    // Requester index as it travels with each beat
    typedef logic [REQ_ID_WIDTH-1:0] req_id_t;

    // Transfer state machine encoding
    typedef enum logic [1:0] {
        XFER_IDLE  = 2'd0, // Waiting for a valid requester to arbitrate
        XFER_BURST = 2'd1  // A grant is locked until its last beat is taken
    } xfer_state_t;

endpackage

//--- hdl/qos_arbiter.sv
`timescale 1ns/10ps

module qos_arbiter (
    input  qos_pkg::qos_config_t                 qos_config_i [port_pkg::NUM_REQUESTERS-1:0],
    input  logic                                 req_valid_i  [port_pkg::NUM_REQUESTERS-1:0],
    output logic [port_pkg::NUM_REQUESTERS-1:0]  grant_o,
    output logic [qos_pkg::BURST_LEN_WIDTH-1:0]  granted_burst_len_o
);

    import qos_pkg::*;
    import port_pkg::*;

    // Number of distinct QoS levels the search walks through
    localparam int NUM_LEVELS = 4;

    logic [NUM_REQUESTERS-1:0]  grant_int; // One-hot winner before it leaves the block
    logic [BURST_LEN_WIDTH-1:0] len_int;   // Burst length of the winner

    // Search starts at the most urgent level and walks down
    // Inside one level the lowest index is visited first, so it wins the tie
    always_comb begin
        logic found;
        found     = 1'b0;
        grant_int = '0;
        len_int   = '0;
        for (int lvl = NUM_LEVELS - 1; lvl >= 0; lvl--) begin
            for (int j = 0; j < NUM_REQUESTERS; j++) begin
                if (!found && req_valid_i[j] &&
                    (qos_config_i[j].qos_level == qos_level_t'(lvl))) begin
                    found        = 1'b1;                     // Freeze the search
                    grant_int[j] = 1'b1;
                    len_int      = qos_config_i[j].burst_len; // Winner decides the burst size
                end
            end
        end
    end

    // No valid request leaves both outputs at zero
    assign grant_o             = grant_int;
    assign granted_burst_len_o = len_int;

endmodule

//--- hdl/xfer_fsm.sv
`timescale 1ns/10ps

module xfer_fsm (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic [port_pkg::NUM_REQUESTERS-1:0] arb_grant_i,   // Combinational winner
    input  logic                                beat_accept_i, // A beat of the burst was taken
    input  logic                                last_beat_i,   // Counter sits on the final beat
    output logic [port_pkg::NUM_REQUESTERS-1:0] grant_o,
    output port_pkg::req_id_t                   grant_id_o,
    output logic                                burst_start_o,
    output logic                                busy_o
);

    import port_pkg::*;

    xfer_state_t               state_q;
    logic [NUM_REQUESTERS-1:0] grant_q;    // Locked one-hot grant
    req_id_t                   grant_id_q; // Locked grant as an index for the beat select
    req_id_t                   arb_id;     // Index of the current arbiter winner

    // Encode the one-hot arbiter output into an index
    always_comb begin
        arb_id = '0;
        for (int i = 0; i < NUM_REQUESTERS; i++) begin
            if (arb_grant_i[i]) begin
                arb_id = req_id_t'(i);
            end
        end
    end

    // A burst starts on any cycle in idle that sees a winner
    assign burst_start_o = (state_q == XFER_IDLE) && (|arb_grant_i);
    assign busy_o        = (state_q == XFER_BURST);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= XFER_IDLE;
            grant_q    <= '0;
            grant_id_q <= '0;
        end else begin
            case (state_q)
                XFER_IDLE: begin
                    if (burst_start_o) begin
                        state_q    <= XFER_BURST;
                        grant_q    <= arb_grant_i; // Winner is locked for the whole burst
                        grant_id_q <= arb_id;
                    end
                end
                XFER_BURST: begin
                    // Final beat taken, drop the grant so one idle cycle follows
                    if (beat_accept_i && last_beat_i) begin
                        state_q <= XFER_IDLE;
                        grant_q <= '0;
                    end
                end
                default: begin
                    state_q <= XFER_IDLE;
                    grant_q <= '0;
                end
            endcase
        end
    end

    assign grant_o    = grant_q;
    assign grant_id_o = grant_id_q;

endmodule

//--- hdl/beat_counter.sv
`timescale 1ns/10ps

module beat_counter (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                burst_start_i, // New grant is being latched
    input  logic [qos_pkg::BURST_LEN_WIDTH-1:0] burst_len_i,   // Beats minus one of that grant
    input  logic                                beat_accept_i,
    output logic                                last_beat_o
);

    import qos_pkg::*;

    logic [BURST_LEN_WIDTH-1:0] len_q;   // Stored length of the running burst
    logic [BURST_LEN_WIDTH-1:0] count_q; // Beats already taken in this burst

    // The start of a burst wins over a stray accept in the same cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            len_q   <= '0;
            count_q <= '0;
        end else if (burst_start_i) begin
            len_q   <= burst_len_i;
            count_q <= '0;
        end else if (beat_accept_i) begin
            count_q <= count_q + 1'b1; // Wraps only after the final beat, then restarts
        end
    end

    // High while the beat offered now is the one that closes the burst
    assign last_beat_o = (count_q == len_q);

endmodule

//--- hdl/beat_slice.sv
`timescale 1ns/10ps

module beat_slice (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            load_i,      // Beat accepted from the requester
    input  logic [port_pkg::DATA_WIDTH-1:0] data_i,
    input  port_pkg::req_id_t               id_i,
    input  logic                            last_i,
    input  logic                            out_ready_i,
    output logic                            can_load_o,
    output logic                            out_valid_o,
    output logic [port_pkg::DATA_WIDTH-1:0] out_data_o,
    output port_pkg::req_id_t               out_id_o,
    output logic                            out_last_o
);

    import port_pkg::*;

    logic                  valid_q; // Slot holds a beat
    logic                  last_q;
    logic [DATA_WIDTH-1:0] data_q;
    req_id_t               id_q;

    // Room exists when the slot is empty or its beat leaves on this edge
    assign can_load_o = !valid_q || out_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
            last_q  <= last_i;
        end else if (out_ready_i) begin
            valid_q <= 1'b0; // Departure without a refill empties the slot
            last_q  <= 1'b0;
        end
    end

    // Payload only moves on a load, so it holds steady under back-pressure
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            data_q <= data_i;
            id_q   <= id_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;
    assign out_id_o    = id_q;
    assign out_last_o  = last_q;

endmodule

//--- hdl/qos_port_top.sv
`timescale 1ns/10ps

module qos_port_top (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                req_valid_i  [port_pkg::NUM_REQUESTERS-1:0],
    input  qos_pkg::qos_config_t                qos_config_i [port_pkg::NUM_REQUESTERS-1:0],
    input  logic [port_pkg::DATA_WIDTH-1:0]     req_data_i   [port_pkg::NUM_REQUESTERS-1:0],
    output logic                                req_ready_o  [port_pkg::NUM_REQUESTERS-1:0],
    output logic [port_pkg::NUM_REQUESTERS-1:0] grant_o,
    input  logic                                out_ready_i,
    output logic                                out_valid_o,
    output logic [port_pkg::DATA_WIDTH-1:0]     out_data_o,
    output port_pkg::req_id_t                   out_id_o,
    output logic                                out_last_o
);

    import qos_pkg::*;
    import port_pkg::*;

    logic [NUM_REQUESTERS-1:0]  arb_grant;   // Live arbiter winner, used only in idle
    logic [BURST_LEN_WIDTH-1:0] arb_len;     // Burst length of that winner
    req_id_t                    grant_id;    // Locked requester index
    logic                       burst_start;
    logic                       busy;
    logic                       last_beat;
    logic                       can_load;
    logic                       beat_accept;

    qos_arbiter u_arbiter (
        .qos_config_i        (qos_config_i),
        .req_valid_i         (req_valid_i),
        .grant_o             (arb_grant),
        .granted_burst_len_o (arb_len)
    );

    xfer_fsm u_fsm (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .arb_grant_i   (arb_grant),
        .beat_accept_i (beat_accept),
        .last_beat_i   (last_beat),
        .grant_o       (grant_o),
        .grant_id_o    (grant_id),
        .burst_start_o (burst_start),
        .busy_o        (busy)
    );

    beat_counter u_counter (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .burst_start_i (burst_start),
        .burst_len_i   (arb_len), // Sampled on the same edge that locks the grant
        .beat_accept_i (beat_accept),
        .last_beat_o   (last_beat)
    );

    // The granted requester offers a beat, the slice takes it if there is room
    assign beat_accept = busy && req_valid_i[grant_id] && can_load;

    beat_slice u_slice (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (beat_accept),
        .data_i      (req_data_i[grant_id]),
        .id_i        (grant_id),
        .last_i      (last_beat),
        .out_ready_i (out_ready_i),
        .can_load_o  (can_load),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_id_o    (out_id_o),
        .out_last_o  (out_last_o)
    );

    // Only the locked requester sees ready, and only while the slice can take a beat
    for (genvar r = 0; r < NUM_REQUESTERS; r++) begin : gen_ready
        assign req_ready_o[r] = grant_o[r] && busy && can_load;
    end

endmodule

//--- verification/qos_port_tb.sv
`timescale 1ns/10ps

module qos_port_tb;

    import qos_pkg::*;
    import port_pkg::*;

    localparam int NUM_BURSTS      = 200;                        // Bursts that must leave the port
    localparam int WATCHDOG_CYCLES = NUM_BURSTS * 16 * 4 + 1000; // Longest bursts, slow sink, margin

    // One expected beat on the output stream
    typedef struct packed {
        req_id_t               id;
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } beat_t;

    logic                       clk_i;
    logic                       rst_n_i;
    logic                       req_valid_i  [NUM_REQUESTERS-1:0];
    qos_config_t                qos_config_i [NUM_REQUESTERS-1:0];
    logic [DATA_WIDTH-1:0]      req_data_i   [NUM_REQUESTERS-1:0];
    logic                       req_ready_o  [NUM_REQUESTERS-1:0];
    logic [NUM_REQUESTERS-1:0]  grant_o;
    logic                       out_ready_i;
    logic                       out_valid_o;
    logic [DATA_WIDTH-1:0]      out_data_o;
    req_id_t                    out_id_o;
    logic                       out_last_o;

    logic                       active   [NUM_REQUESTERS-1:0]; // Requester holds a burst
    logic [2:0]                 gap      [NUM_REQUESTERS-1:0]; // Idle cycles before its next burst
    logic [15:0]                seq      [NUM_REQUESTERS-1:0]; // Burst number per requester
    logic [BURST_LEN_WIDTH-1:0] beat_idx [NUM_REQUESTERS-1:0]; // Beat offered right now
    qos_config_t                cur_cfg  [NUM_REQUESTERS-1:0];
    logic                       accepted [NUM_REQUESTERS-1:0]; // Beat taken at the coming edge

    logic                       snap_valid [NUM_REQUESTERS-1:0]; // Inputs seen in the last cycle
    qos_config_t                snap_cfg   [NUM_REQUESTERS-1:0];
    logic [NUM_REQUESTERS-1:0]  prev_grant;
    logic                       burst_ended; // Final beat of the locked burst taken at the edge
    logic                       slot_full;   // Output slot holds a beat in the coming cycle

    beat_t                      exp_q [$]; // Beats still owed by the port, oldest first
    int                         bursts_seen;
    logic [31:0]                rng_state;

    qos_port_top dut0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .qos_config_i (qos_config_i),
        .req_data_i   (req_data_i),
        .req_ready_o  (req_ready_o),
        .grant_o      (grant_o),
        .out_ready_i  (out_ready_i),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_id_o     (out_id_o),
        .out_last_o   (out_last_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i; // 10 ns period
    end

    // Ends a run that stopped making progress
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the port did not deliver all bursts in the allowed time");
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Requester id, then its burst number, then the beat index
    function automatic logic [DATA_WIDTH-1:0] make_word(input int r, input logic [15:0] s,
                                                       input logic [BURST_LEN_WIDTH-1:0] b);
        return {8'(r), s, 4'h0, b};
    endfunction

    // Highest level wins and a later requester needs a strictly higher level to take over
    function automatic int pick_winner();
        int best;
        best = -1;
        for (int r = 0; r < NUM_REQUESTERS; r++) begin
            if (snap_valid[r] &&
                (best < 0 || snap_cfg[r].qos_level > snap_cfg[best].qos_level)) begin
                best = r;
            end
        end
        return best;
    endfunction

    function automatic logic [NUM_REQUESTERS-1:0] ready_vector();
        logic [NUM_REQUESTERS-1:0] v;
        for (int r = 0; r < NUM_REQUESTERS; r++) v[r] = req_ready_o[r];
        return v;
    endfunction

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "Mismatch at time %0t", $time);
    endtask

    task automatic check_grant(input string name, input logic [NUM_REQUESTERS-1:0] got,
                               input logic [NUM_REQUESTERS-1:0] expected);
        if (got !== expected) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, expected);
            stop_run();
        end
    endtask

    task automatic check_id(input string name, input req_id_t got, input req_id_t expected);
        if (got !== expected) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, expected);
            stop_run();
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] expected,
                              input logic got_last, input logic exp_last);
        if (got !== expected) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, expected);
            stop_run();
        end
        if (got_last !== exp_last) begin
            $display("ERROR out_last_o got 0x%h expected 0x%h", got_last, exp_last);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, expected);
            stop_run();
        end
    endtask

    task automatic check_reset_outputs();
        check_grant("grant_o", grant_o, '0);
        check_grant("req_ready_o", ready_vector(), '0);
        check_flag("out_valid_o", out_valid_o, 1'b0);
        check_flag("out_last_o", out_last_o, 1'b0);
    endtask

    // All beats of a newly granted burst go to the back of the queue
    task automatic enqueue_burst(input int w);
        beat_t entry;
        for (int b = 0; b <= int'(snap_cfg[w].burst_len); b++) begin
            entry.id   = req_id_t'(w);
            entry.data = make_word(w, seq[w], 4'(b));
            entry.last = (b == int'(snap_cfg[w].burst_len));
            exp_q.push_back(entry);
        end
    endtask

    // Checks the DUT at the falling edge where every output has settled
    task automatic check_cycle();
        logic [NUM_REQUESTERS-1:0] exp_grant;
        logic [NUM_REQUESTERS-1:0] exp_ready;
        beat_t                     head;
        int                        w;
        w         = pick_winner();
        exp_grant = '0;
        if (prev_grant == '0) begin
            if (w >= 0) exp_grant[w] = 1'b1; // Idle in the last cycle, so arbitration happened
        end else if (!burst_ended) begin
            exp_grant = prev_grant; // Grant stays locked mid-burst
        end
        check_grant("grant_o", grant_o, exp_grant);
        if (prev_grant == '0 && w >= 0) enqueue_burst(w);
        // Locked requester may hand over a beat when the slot is free or draining
        exp_ready = exp_grant & {NUM_REQUESTERS{!slot_full || out_ready_i}};
        check_grant("req_ready_o", ready_vector(), exp_ready);
        check_flag("out_valid_o", out_valid_o, slot_full);
        if (slot_full) begin
            head = exp_q[0];
            check_id("out_id_o", out_id_o, head.id);
            check_data("out_data_o", out_data_o, head.data, out_last_o, head.last);
            if (out_ready_i) begin
                void'(exp_q.pop_front()); // Held beat is compared again until it leaves
                if (head.last) bursts_seen++;
            end
        end else begin
            check_flag("out_last_o", out_last_o, 1'b0);
        end
        slot_full   = slot_full && !out_ready_i; // Beat in the slot leaves on a ready sink
        burst_ended = 1'b0;
        for (int r = 0; r < NUM_REQUESTERS; r++) begin
            accepted[r] = req_valid_i[r] && exp_ready[r];
            if (accepted[r]) slot_full = 1'b1; // A loaded beat is shown after the edge
            if (accepted[r] && beat_idx[r] == cur_cfg[r].burst_len) burst_ended = 1'b1;
            snap_valid[r] = req_valid_i[r];
            snap_cfg[r]   = qos_config_i[r];
        end
        prev_grant = exp_grant;
    endtask

    // Advances every requester past the edge and drives the next inputs
    task automatic step_requesters();
        for (int r = 0; r < NUM_REQUESTERS; r++) begin
            if (accepted[r]) begin
                if (beat_idx[r] == cur_cfg[r].burst_len) begin
                    active[r]   = 1'b0; // Own model saw the final beat go
                    seq[r]      = seq[r] + 16'd1;
                    beat_idx[r] = '0;
                    rng_state   = xorshift32(rng_state);
                    gap[r]      = rng_state[2:0];
                end else begin
                    beat_idx[r] = beat_idx[r] + 4'd1;
                end
            end
            if (!active[r]) begin
                if (gap[r] == 3'd0) begin
                    rng_state                = xorshift32(rng_state);
                    active[r]                = 1'b1;
                    cur_cfg[r].qos_level     = qos_level_t'(rng_state[9:8]);
                    cur_cfg[r].burst_len     = rng_state[7:4];
                    beat_idx[r]              = '0;
                end else begin
                    gap[r] = gap[r] - 3'd1;
                end
            end
            req_valid_i[r]  = active[r];
            qos_config_i[r] = cur_cfg[r];
            req_data_i[r]   = make_word(r, seq[r], beat_idx[r]);
        end
        rng_state   = xorshift32(rng_state);
        out_ready_i = (rng_state % 32'd10) >= 32'd3; // Sink stalls about 30% of the time
    endtask

    initial begin
        rst_n_i     = 1'b0;
        out_ready_i = 1'b0;
        rng_state   = 32'h30d;
        prev_grant  = '0;
        burst_ended = 1'b0;
        slot_full   = 1'b0;
        bursts_seen = 0;
        for (int r = 0; r < NUM_REQUESTERS; r++) begin
            req_valid_i[r]  = 1'b0;
            qos_config_i[r] = '0;
            req_data_i[r]   = '0;
            active[r]       = 1'b0;
            seq[r]          = '0;
            beat_idx[r]     = '0;
            cur_cfg[r]      = '0;
            accepted[r]     = 1'b0;
            snap_valid[r]   = 1'b0;
            snap_cfg[r]     = '0;
            rng_state       = xorshift32(rng_state);
            gap[r]          = rng_state[2:0]; // Staggered first requests
        end
        repeat (3) begin
            @(negedge clk_i);
            check_reset_outputs();
        end
        @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        while (bursts_seen < NUM_BURSTS) begin
            step_requesters();
            @(negedge clk_i);
            check_cycle();
            @(posedge clk_i);
            #1; // Inputs change a little after the edge
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- all.f
hdl/qos_pkg.sv
hdl/port_pkg.sv
hdl/qos_arbiter.sv
hdl/xfer_fsm.sv
hdl/beat_counter.sv
hdl/beat_slice.sv
hdl/qos_port_top.sv
verification/qos_port_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the QoS port testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=qos_port_tb
BUILD_DIR=obj_dir
LOG=sim.log
FAIL_PATTERN="Done: errors found"
PASS_PATTERN="Done: no errors"

verilator --binary -j 0 --top-module "$TOP" -Mdir "$BUILD_DIR" -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_PATTERN" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "$PASS_PATTERN" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

echo "Simulation PASSED"
exit 0
